//--- hw/wb_settings.svh
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// Byte-addressed bus widths
`define WB_ADR_WIDTH 16
`define WB_DAT_WIDTH 32
`define WB_SEL_WIDTH (`WB_DAT_WIDTH / 8)

// Queue depths
`define WB_CMD_DEPTH 8
`define WB_RSP_DEPTH 4

// RAM size in words
`define WB_RAM_WORDS 256

// Word address bits that set the slave wait states
`define WB_WAIT_MASK 3

`endif

//--- hw/wb_pkg.sv
`include "wb_settings.svh"

package wb_pkg;

    // One queued command
    typedef struct packed {
        logic                       we;
        logic [`WB_ADR_WIDTH-1:0]   adr;
        logic [`WB_SEL_WIDTH-1:0]   sel;
        logic [`WB_DAT_WIDTH-1:0]   dat;
    } wb_cmd_t;

    // One read result
    typedef struct packed {
        logic [`WB_ADR_WIDTH-1:0]   adr;
        logic [`WB_DAT_WIDTH-1:0]   dat;
    } wb_rsp_t;

    // Master side of the bus
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`WB_ADR_WIDTH-1:0]   adr;
        logic [`WB_SEL_WIDTH-1:0]   sel;
        logic [`WB_DAT_WIDTH-1:0]   dat_wr;
    } wb_req_t;

    // Slave side of the bus
    typedef struct packed {
        logic                       ack;
        logic [`WB_DAT_WIDTH-1:0]   dat_rd;
    } wb_ack_t;

endpackage

//--- hw/wb_sync_fifo.sv
`timescale 1ns/1ps

module wb_sync_fifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           push,
    input  payload_t                       push_data,
    input  logic                           pop,
    output payload_t                       head,
    output logic                           empty,
    output logic                           full,
    output logic [$clog2(depth + 1) - 1:0] count
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_w = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] used;
    logic             do_push;
    logic             do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head  = mem[rd_ptr];
    assign empty = (used == '0);
    assign full  = (used == cnt_w'(depth));
    assign count = used;

    // Storage array
    always_ff @(posedge clock) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (do_push) begin
                if (wr_ptr == ptr_w'(depth - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (do_pop) begin
                if (rd_ptr == ptr_w'(depth - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Occupancy moves only when one side acts alone
            if (do_push && !do_pop) begin
                used <= used + 1'b1;
            end else if (do_pop && !do_push) begin
                used <= used - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (
        @(posedge clock) disable iff (!reset) push |-> !full
    ) else $error("wb_sync_fifo: push while full");

    a_no_underflow: assert property (
        @(posedge clock) disable iff (!reset) pop |-> !empty
    ) else $error("wb_sync_fifo: pop while empty");

endmodule

//--- hw/wb_bus_master.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_bus_master (
    input  logic                                    clock,
    input  logic                                    reset,
    input  wb_pkg::wb_cmd_t                         cmd_head,
    input  logic                                    cmd_empty,
    output logic                                    cmd_pop,
    input  logic [$clog2(`WB_RSP_DEPTH + 1) - 1:0]  rsp_count,
    output logic                                    rsp_push,
    output wb_pkg::wb_rsp_t                         rsp_data,
    output wb_pkg::wb_req_t                         bus_req,
    input  wb_pkg::wb_ack_t                         bus_ack
);

    import wb_pkg::*;

    localparam int rsp_cnt_w = $clog2(`WB_RSP_DEPTH + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_active,
        st_release
    } state_t;

    state_t             state;
    logic               cyc_q;
    logic               stb_q;
    wb_cmd_t            cmd_q;
    logic [rsp_cnt_w:0] rsp_pending;
    logic               rsp_room;
    logic               can_start;

    // A push in the release cycle is not yet in the FIFO count
    assign rsp_pending = {1'b0, rsp_count} + {{rsp_cnt_w{1'b0}}, rsp_push};
    assign rsp_room    = rsp_pending < (rsp_cnt_w + 1)'(`WB_RSP_DEPTH);

    assign can_start = (state == st_idle || state == st_release) && !cmd_empty &&
                       (cmd_head.we || rsp_room);
    assign cmd_pop   = can_start;

    assign bus_req = '{
        cyc:    cyc_q,
        stb:    stb_q,
        we:     cmd_q.we,
        adr:    cmd_q.adr,
        sel:    cmd_q.sel,
        dat_wr: cmd_q.dat
    };

    always_ff @(posedge clock) begin
        if (!reset) begin
            state    <= st_idle;
            cyc_q    <= 1'b0;
            stb_q    <= 1'b0;
            rsp_push <= 1'b0;
        end else begin
            rsp_push <= 1'b0;
            case (state)
                st_idle, st_release: begin
                    if (can_start) begin
                        state <= st_active;
                        cyc_q <= 1'b1;
                        stb_q <= 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_active: begin
                    if (bus_ack.ack) begin
                        state    <= st_release;
                        cyc_q    <= 1'b0;
                        stb_q    <= 1'b0;
                        rsp_push <= !cmd_q.we;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Request fields stay put for the whole cycle
    always_ff @(posedge clock) begin
        if (can_start) begin
            cmd_q <= cmd_head;
        end
    end

    // Read data captured on the ack edge
    always_ff @(posedge clock) begin
        if (state == st_active && bus_ack.ack && !cmd_q.we) begin
            rsp_data <= '{adr: cmd_q.adr, dat: bus_ack.dat_rd};
        end
    end

    // An ack outside the active state would be lost
    a_ack_while_active: assert property (
        @(posedge clock) disable iff (!reset) bus_ack.ack |-> state == st_active
    ) else $error("wb_bus_master: ack outside an active cycle");

endmodule

//--- hw/wb_ram_slave.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_ram_slave (
    input  logic            clock,
    input  logic            reset,
    input  wb_pkg::wb_req_t bus_req,
    output wb_pkg::wb_ack_t bus_ack
);

    import wb_pkg::*;

    localparam int word_w = $clog2(`WB_RAM_WORDS);
    localparam int wait_w = $clog2(`WB_WAIT_MASK + 1);

    logic [`WB_DAT_WIDTH-1:0] mem [`WB_RAM_WORDS];
    logic [word_w-1:0]        word;
    logic [wait_w-1:0]        wait_load;
    logic [wait_w-1:0]        wait_cnt;
    logic                     busy;
    logic                     req_live;
    logic                     ack;

    // Byte address to word index
    assign word      = bus_req.adr[word_w + 1:2];
    assign wait_load = word[wait_w-1:0] & wait_w'(`WB_WAIT_MASK);

    assign req_live = bus_req.cyc && bus_req.stb;

    // First strobe cycle uses the fresh count, later ones the counter
    assign ack = req_live && (busy ? (wait_cnt == '0) : (wait_load == '0));

    assign bus_ack = '{ack: ack, dat_rd: mem[word]};

    always_ff @(posedge clock) begin
        if (!reset) begin
            busy     <= 1'b0;
            wait_cnt <= '0;
        end else begin
            if (ack) begin
                busy <= 1'b0;
            end else if (req_live) begin
                if (!busy) begin
                    busy     <= 1'b1;
                    wait_cnt <= wait_load - 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1'b1;
                end
            end
        end
    end

    // Merge selected bytes on the ack edge
    always_ff @(posedge clock) begin
        if (ack && bus_req.we) begin
            for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
                if (bus_req.sel[b]) begin
                    mem[word][8*b +: 8] <= bus_req.dat_wr[8*b +: 8];
                end
            end
        end
    end

    a_wait_bounded: assert property (
        @(posedge clock) disable iff (!reset)
        req_live && !busy |-> ##[0:`WB_WAIT_MASK] ack
    ) else $error("wb_ram_slave: ack later than the wait-state count");

endmodule

//--- hw/wb_protocol_monitor.sv
`timescale 1ns/1ps

module wb_protocol_monitor (
    input  logic            clock,
    input  logic            reset,
    input  wb_pkg::wb_req_t bus_req,
    input  wb_pkg::wb_ack_t bus_ack,
    output logic            protocol_error
);

    import wb_pkg::*;

    logic    past_valid = 1'b0;
    logic    prev_reset;
    wb_req_t prev_req;
    wb_ack_t prev_ack;
    logic    live;
    logic    hold;
    logic    bad_reset;
    logic    bad_stb;
    logic    bad_ack;
    logic    bad_stable;
    logic    bad_drop;
    logic    bad_long;

    // Previous cycle's bus for the error level
    always_ff @(posedge clock) begin
        past_valid <= 1'b1;
        prev_reset <= reset;
        prev_req   <= bus_req;
        prev_ack   <= bus_ack;
    end

    assign live = past_valid && reset && prev_reset;
    assign hold = live && prev_req.stb && !prev_ack.ack;

    assign bad_reset  = past_valid && !prev_reset && (bus_req.cyc || bus_req.stb);
    assign bad_stb    = reset && bus_req.stb && !bus_req.cyc;
    assign bad_ack    = reset && bus_ack.ack && !bus_req.stb;
    assign bad_stable = hold && bus_req.stb &&
                        (bus_req.we != prev_req.we || bus_req.adr != prev_req.adr ||
                         bus_req.sel != prev_req.sel || bus_req.dat_wr != prev_req.dat_wr);
    assign bad_drop   = hold && !bus_req.stb;
    assign bad_long   = live && prev_ack.ack && bus_ack.ack;

    always_ff @(posedge clock) begin
        if (!reset) begin
            protocol_error <= 1'b0;
        end else if (bad_reset || bad_stb || bad_ack || bad_stable || bad_drop || bad_long) begin
            protocol_error <= 1'b1;
        end
    end

    a_reset_idle: assert property (
        @(posedge clock) !reset |=> !bus_req.cyc && !bus_req.stb
    ) else $error("wb monitor: cyc or stb right after reset");

    a_stb_in_cyc: assert property (
        @(posedge clock) disable iff (!reset) bus_req.stb |-> bus_req.cyc
    ) else $error("wb monitor: stb without cyc");

    a_ack_in_stb: assert property (
        @(posedge clock) disable iff (!reset) bus_ack.ack |-> bus_req.stb
    ) else $error("wb monitor: ack without stb");

    a_req_stable: assert property (
        @(posedge clock) disable iff (!reset)
        bus_req.stb && !bus_ack.ack |=>
            $stable(bus_req.we) && $stable(bus_req.adr) &&
            $stable(bus_req.sel) && $stable(bus_req.dat_wr)
    ) else $error("wb monitor: request changed while waiting for ack");

    a_stb_held: assert property (
        @(posedge clock) disable iff (!reset) bus_req.stb && !bus_ack.ack |=> bus_req.stb
    ) else $error("wb monitor: stb released without ack");

    a_ack_single: assert property (
        @(posedge clock) disable iff (!reset) bus_ack.ack |=> !bus_ack.ack
    ) else $error("wb monitor: ack held longer than one cycle");

endmodule

//--- hw/wb_xfer_top.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_xfer_top (
    input  logic            clock,
    input  logic            reset,
    input  logic            cmd_strobe,
    input  wb_pkg::wb_cmd_t cmd,
    output logic            cmd_full,
    output logic            rsp_strobe,
    output wb_pkg::wb_rsp_t rsp,
    output logic            protocol_error
);

    import wb_pkg::*;

    wb_cmd_t                                cmd_head;
    logic                                   cmd_empty;
    logic                                   cmd_pop;
    logic [$clog2(`WB_RSP_DEPTH + 1) - 1:0] rsp_count;
    logic                                   rsp_push;
    wb_rsp_t                                rsp_data;
    logic                                   rsp_empty;
    wb_req_t                                bus_req;
    wb_ack_t                                bus_ack;

    // Responses leave as soon as they land
    assign rsp_strobe = !rsp_empty;

    wb_sync_fifo #(
        .payload_t (wb_cmd_t),
        .depth     (`WB_CMD_DEPTH)
    ) u_cmd_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (cmd_strobe),
        .push_data (cmd),
        .pop       (cmd_pop),
        .head      (cmd_head),
        .empty     (cmd_empty),
        .full      (cmd_full),
        .count     ()
    );

    wb_sync_fifo #(
        .payload_t (wb_rsp_t),
        .depth     (`WB_RSP_DEPTH)
    ) u_rsp_fifo (
        .clock     (clock),
        .reset     (reset),
        .push      (rsp_push),
        .push_data (rsp_data),
        .pop       (rsp_strobe),
        .head      (rsp),
        .empty     (rsp_empty),
        .full      (),
        .count     (rsp_count)
    );

    wb_bus_master u_bus_master (
        .clock     (clock),
        .reset     (reset),
        .cmd_head  (cmd_head),
        .cmd_empty (cmd_empty),
        .cmd_pop   (cmd_pop),
        .rsp_count (rsp_count),
        .rsp_push  (rsp_push),
        .rsp_data  (rsp_data),
        .bus_req   (bus_req),
        .bus_ack   (bus_ack)
    );

    wb_ram_slave u_ram_slave (
        .clock   (clock),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_ack (bus_ack)
    );

    wb_protocol_monitor u_protocol_monitor (
        .clock          (clock),
        .reset          (reset),
        .bus_req        (bus_req),
        .bus_ack        (bus_ack),
        .protocol_error (protocol_error)
    );

endmodule

//--- bench/wb_xfer_tb.sv
`timescale 1ns/1ps
`include "wb_settings.svh"

module wb_xfer_tb;

    import wb_pkg::*;

    localparam int     n_words    = 32;
    localparam int     total_cmds = 2 * n_words + 48 + 16 + 48 + 1;
    // Worst command is 6 cycles plus one gap
    localparam longint timeout_ns = total_cmds * 7 * 20 + 2000;

    logic    clock = 1'b0;
    logic    reset;
    logic    cmd_strobe;
    wb_cmd_t cmd;
    logic    cmd_full;
    logic    rsp_strobe;
    wb_rsp_t rsp;
    logic    protocol_error;

    logic [31:0]              rng = 32'hd4eb08f0;
    logic [`WB_DAT_WIDTH-1:0] ref_mem [n_words];
    wb_rsp_t                  expected [$];
    logic                     saw_full = 1'b0;

    wb_xfer_top i_wb_xfer_top (
        .clock          (clock),
        .reset          (reset),
        .cmd_strobe     (cmd_strobe),
        .cmd            (cmd),
        .cmd_full       (cmd_full),
        .rsp_strobe     (rsp_strobe),
        .rsp            (rsp),
        .protocol_error (protocol_error)
    );

    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift(rng);
        return rng;
    endfunction

    // Selected bytes come from the new word
    function automatic logic [`WB_DAT_WIDTH-1:0] merge_bytes(
        input logic [`WB_DAT_WIDTH-1:0] old_word,
        input logic [`WB_DAT_WIDTH-1:0] new_word,
        input logic [`WB_SEL_WIDTH-1:0] sel
    );
        logic [`WB_DAT_WIDTH-1:0] merged;
        merged = old_word;
        for (int b = 0; b < `WB_SEL_WIDTH; b++) begin
            if (sel[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0)
        else report_failure($sformatf("FAIL %s got %h expected 0", name, value));
    endtask

    // Strobe every other cycle so the falling-edge full check holds
    task automatic send(
        input logic                     we,
        input logic [4:0]               word,
        input logic [`WB_SEL_WIDTH-1:0] sel,
        input logic [`WB_DAT_WIDTH-1:0] dat
    );
        wb_cmd_t c;
        wb_rsp_t r;
        c.we       = we;
        c.adr      = '0;
        c.adr[6:2] = word;
        c.sel      = sel;
        c.dat      = dat;
        @(negedge clock);
        while (cmd_full) begin
            saw_full = 1'b1;
            @(negedge clock);
        end
        @(posedge clock);
        cmd_strobe <= 1'b1;
        cmd        <= c;
        // In-order execution lets the model move at issue time
        if (we) begin
            ref_mem[word] = merge_bytes(ref_mem[word], dat, sel);
        end else begin
            r.adr = c.adr;
            r.dat = ref_mem[word];
            expected.push_back(r);
        end
        @(posedge clock);
        cmd_strobe <= 1'b0;
    endtask

    initial begin : stimulus
        logic [4:0]  words [24];
        logic [31:0] r;
        int          burst;
        reset      = 1'b0;
        cmd_strobe = 1'b0;
        cmd        = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b1;

        // Idle levels before any command
        @(negedge clock);
        check_low("rsp_strobe", rsp_strobe);
        check_low("cmd_full", cmd_full);
        check_low("protocol_error", protocol_error);

        // Full words first so every later read sees known data
        for (int w = 0; w < n_words; w++) begin
            send(1'b1, 5'(w), '1, next_random());
        end
        for (int w = 0; w < n_words; w++) begin
            send(1'b0, 5'(w), '0, '0);
        end

        // Partial writes under random byte selects
        for (int i = 0; i < 24; i++) begin
            r = next_random();
            words[i] = r[4:0];
            send(1'b1, r[4:0], r[11:8], next_random());
        end
        for (int i = 0; i < 24; i++) begin
            send(1'b0, words[i], '0, '0);
        end

        // Words 16 to 23 hit each wait-state count twice
        for (int w = 16; w < 24; w++) begin
            send(1'b1, 5'(w), '1, next_random());
        end
        for (int w = 16; w < 24; w++) begin
            send(1'b0, 5'(w), '0, '0);
        end

        // Slowest addresses only until the command FIFO fills
        saw_full = 1'b0;
        burst    = 0;
        while (!saw_full && burst < 40) begin
            r = next_random();
            send(r[1:0] == 2'b00, {r[4:2], 2'b11}, r[11:8], next_random());
            burst++;
        end
        assert (saw_full)
        else report_failure("the command FIFO never filled during the burst");
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            send(1'b0, r[4:0], '0, '0);
        end
        send(1'b0, 5'd0, '0, '0);

        while (expected.size() != 0) begin
            @(negedge clock);
        end
        // Room for any stray extra response
        repeat (10) @(negedge clock);
        if (protocol_error !== 1'b0) begin
            report_failure($sformatf("FAIL protocol_error got %h expected 0", protocol_error));
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

    initial begin : compare_responses
        wb_rsp_t want;
        forever begin
            @(posedge clock);
            if (reset) begin
                assert (protocol_error === 1'b0)
                else report_failure(
                    $sformatf("FAIL protocol_error got %h expected 0", protocol_error));
                if (rsp_strobe === 1'b1) begin
                    assert (expected.size() > 0)
                    else report_failure("a response arrived with no read outstanding");
                    want = expected.pop_front();
                    assert (rsp.adr === want.adr)
                    else report_failure(
                        $sformatf("FAIL rsp.adr got %h expected %h", rsp.adr, want.adr));
                    assert (rsp.dat === want.dat)
                    else report_failure(
                        $sformatf("FAIL rsp.dat got %h expected %h", rsp.dat, want.dat));
                end
            end
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        report_failure($sformatf("timeout: the run did not finish within %0d ns", timeout_ns));
    end

endmodule

//--- wb_xfer.f
+incdir+hw
hw/wb_pkg.sv
hw/wb_sync_fifo.sv
hw/wb_bus_master.sv
hw/wb_ram_slave.sv
hw/wb_protocol_monitor.sv
hw/wb_xfer_top.sv
bench/wb_xfer_tb.sv
